// ==== build.f ====
+incdir+hw
+incdir+verification
hw/rob_pkg.sv
hw/rob_alloc.sv
hw/rob_entry_array.sv
hw/rob_except_sel.sv
hw/rob_commit.sv
hw/rob_top.sv
verification/tb_rob.sv

// ==== hw/rob_alloc.sv ====
/*
  reorder buffer pointers
  allocation pointer moves on dispatch, retirement pointer on retire
  both carry a wrap bit above the entry index
*/
`timescale 1ns/10ps

module rob_alloc (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  logic             i_retire,
  output rob_pkg::cmt_id_t o_in_cmt_id,
  output rob_pkg::cmt_id_t o_out_cmt_id
);

  rob_pkg::cmt_id_t r_in_cmt_id;   // next id handed to dispatch
  rob_pkg::cmt_id_t r_out_cmt_id;  // id of the head entry

  // ------------------------------
  // allocation side
  // ------------------------------

  // no full check here, the dispatcher runs on returned credits
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_cmt_id <= '0;
    end else if (i_disp_valid) begin
      r_in_cmt_id <= r_in_cmt_id + 1'b1;  // wraps through the msb
    end
  end

  // ------------------------------
  // retirement side
  // ------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_out_cmt_id <= '0;
    end else if (i_retire) begin
      r_out_cmt_id <= r_out_cmt_id + 1'b1;
    end
  end

  assign o_in_cmt_id  = r_in_cmt_id;
  assign o_out_cmt_id = r_out_cmt_id;

endmodule

// ==== hw/rob_cfg.svh ====
/*
  reorder buffer configuration
  sizes of the buffer, the dispatch group and the done report bus
*/
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// ------------------------------
// dispatch and buffer sizes
// ------------------------------
`define ROB_DISP_SIZE     2   // lanes per dispatch group
`define ROB_ENTRY_SIZE    8   // groups held in flight
`define ROB_ENTRY_W       3   // log2 of ROB_ENTRY_SIZE

// ------------------------------
// report bus and payload widths
// ------------------------------
`define ROB_CMT_BUS_SIZE  2   // done ports from execution
`define ROB_PC_W          32
`define ROB_EXC_W         4

`endif

// ==== hw/rob_commit.sv ====
/*
  commit stage
  decides retire and flush for the head entry and registers the
  commit record and the credit pulse
*/
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_commit (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  rob_pkg::cmt_id_t i_out_cmt_id,
  input  logic             i_head_done,
  input  rob_pkg::grp_id_t i_head_grp_id,
  input  rob_pkg::grp_id_t i_head_dead,
  input  rob_pkg::pc_t     i_head_pc,
  input  logic             i_exc_valid,
  input  rob_pkg::cmt_id_t i_exc_cmt_id,
  input  rob_pkg::grp_id_t i_exc_grp_id,
  input  rob_pkg::except_t i_exc_type,
  output logic             o_retire,
  output logic             o_flush,
  output logic             o_cmt_valid,
  output rob_pkg::cmt_id_t o_cmt_id,
  output rob_pkg::grp_id_t o_cmt_grp_id,
  output rob_pkg::grp_id_t o_cmt_dead_id,
  output rob_pkg::grp_id_t o_cmt_except_valid,
  output rob_pkg::except_t o_cmt_except_type,
  output rob_pkg::pc_t     o_cmt_epc,
  output logic             o_credit_return
);

  logic             exc_match;  // held exception sits on the head
  rob_pkg::grp_id_t above_exc;  // lanes younger than the excepting one
  rob_pkg::pc_t     lane_off;

  // ------------------------------
  // excepting lane decode
  // ------------------------------
  always_comb begin
    logic seen;
    seen      = 1'b0;
    above_exc = '0;
    lane_off  = '0;
    for (int k = 0; k < `ROB_DISP_SIZE; k++) begin
      above_exc[k] = seen;
      if (i_exc_grp_id[k] && !seen) begin
        lane_off = rob_pkg::pc_t'(4 * k);
        seen     = 1'b1;
      end
    end
  end

  assign exc_match = i_exc_valid && (i_exc_cmt_id == i_out_cmt_id);
  assign o_retire  = i_head_done;
  // an exception on a lane that is already dead has no effect
  assign o_flush   = o_retire && exc_match && |(i_exc_grp_id & ~i_head_dead);

  // ------------------------------
  // registered commit record
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_cmt_valid     <= 1'b0;
      o_credit_return <= 1'b0;
    end else begin
      o_cmt_valid     <= o_retire;
      o_credit_return <= o_retire;  // one credit per retired group
    end
  end

  always_ff @(posedge i_clk) begin
    o_cmt_id           <= i_out_cmt_id;
    o_cmt_grp_id       <= i_head_grp_id;
    o_cmt_dead_id      <= (i_head_dead | (o_flush ? above_exc : '0)) & i_head_grp_id;
    o_cmt_except_valid <= o_flush ? i_exc_grp_id : '0;
    o_cmt_except_type  <= o_flush ? i_exc_type : '0;
    o_cmt_epc          <= o_flush ? i_head_pc + lane_off : i_head_pc;
  end

endmodule

// ==== hw/rob_entry_array.sv ====
/*
  reorder buffer entry storage
  per entry valid, wrap bit, lanes, done lanes, dead lanes and base pc
  done reports set lane bits, a flush kills every other live entry
*/
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_entry_array (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_disp_valid,
  input  rob_pkg::grp_id_t             i_disp_grp_id,
  input  rob_pkg::pc_t                 i_disp_pc,
  input  rob_pkg::cmt_id_t             i_in_cmt_id,
  input  rob_pkg::cmt_id_t             i_out_cmt_id,
  input  logic [`ROB_CMT_BUS_SIZE-1:0] i_done_valid,
  input  rob_pkg::cmt_id_t             i_done_cmt_id [`ROB_CMT_BUS_SIZE],
  input  rob_pkg::grp_id_t             i_done_grp_id [`ROB_CMT_BUS_SIZE],
  input  logic                         i_retire,
  input  logic                         i_flush,
  output logic                         o_head_done,
  output rob_pkg::grp_id_t             o_head_grp_id,
  output rob_pkg::grp_id_t             o_head_dead,
  output rob_pkg::pc_t                 o_head_pc
);

  rob_pkg::entry_idx_t in_idx;
  rob_pkg::entry_idx_t out_idx;

  logic             r_valid  [`ROB_ENTRY_SIZE];
  logic             r_wrap   [`ROB_ENTRY_SIZE];  // msb of the owning cmt id
  rob_pkg::grp_id_t r_grp_id [`ROB_ENTRY_SIZE];
  rob_pkg::grp_id_t r_done   [`ROB_ENTRY_SIZE];
  rob_pkg::grp_id_t r_dead   [`ROB_ENTRY_SIZE];
  rob_pkg::pc_t     r_pc     [`ROB_ENTRY_SIZE];  // pc of lane 0
  rob_pkg::grp_id_t done_set [`ROB_ENTRY_SIZE];  // lanes reported this cycle

  assign in_idx  = i_in_cmt_id[`ROB_ENTRY_W-1:0];
  assign out_idx = i_out_cmt_id[`ROB_ENTRY_W-1:0];

  // ------------------------------
  // done report decode
  // ------------------------------

  // two ports may hit the same entry in one cycle, so merge first
  always_comb begin
    for (int e = 0; e < `ROB_ENTRY_SIZE; e++) begin
      done_set[e] = '0;
      for (int p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin
        if (i_done_valid[p] && r_valid[e] &&
            i_done_cmt_id[p] == {r_wrap[e], rob_pkg::entry_idx_t'(e)}) begin
          done_set[e] = done_set[e] | i_done_grp_id[p];
        end
      end
    end
  end

  // ------------------------------
  // entry state
  // ------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < `ROB_ENTRY_SIZE; e++) begin
        r_valid[e]  <= 1'b0;
        r_wrap[e]   <= 1'b0;
        r_grp_id[e] <= '0;
        r_done[e]   <= '0;
        r_dead[e]   <= '0;
      end
    end else begin
      for (int e = 0; e < `ROB_ENTRY_SIZE; e++) begin
        r_done[e] <= r_done[e] | done_set[e];
        // younger entries die on a flush, the head retires anyway
        if (i_flush && r_valid[e] && rob_pkg::entry_idx_t'(e) != out_idx) begin
          r_dead[e] <= r_grp_id[e];
        end
      end
      if (i_retire) begin
        r_valid[out_idx] <= 1'b0;
      end
      if (i_disp_valid) begin
        r_valid[in_idx]  <= 1'b1;
        r_wrap[in_idx]   <= i_in_cmt_id[`ROB_ENTRY_W];
        r_grp_id[in_idx] <= i_disp_grp_id;
        r_done[in_idx]   <= '0;
        r_dead[in_idx]   <= i_flush ? i_disp_grp_id : '0;  // same cycle dispatch is killed
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp_valid) begin
      r_pc[in_idx] <= i_disp_pc;
    end
  end

  // ------------------------------
  // head entry view
  // ------------------------------

  // dead lanes count as done
  assign o_head_done   = r_valid[out_idx] && (r_wrap[out_idx] == i_out_cmt_id[`ROB_ENTRY_W]) &&
                         (((r_done[out_idx] | r_dead[out_idx]) & r_grp_id[out_idx]) ==
                          r_grp_id[out_idx]);
  assign o_head_grp_id = r_grp_id[out_idx];
  assign o_head_dead   = r_dead[out_idx];
  assign o_head_pc     = r_pc[out_idx];

endmodule

// ==== hw/rob_except_sel.sv ====
/*
  oldest exception tracker
  picks the oldest excepting done report of a cycle and keeps it
  if it is older than the held one, by cmt id and then by lane
*/
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_except_sel (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic [`ROB_CMT_BUS_SIZE-1:0] i_done_valid,
  input  rob_pkg::cmt_id_t             i_done_cmt_id       [`ROB_CMT_BUS_SIZE],
  input  rob_pkg::grp_id_t             i_done_grp_id       [`ROB_CMT_BUS_SIZE],
  input  logic [`ROB_CMT_BUS_SIZE-1:0] i_done_except_valid,
  input  rob_pkg::except_t             i_done_except_type  [`ROB_CMT_BUS_SIZE],
  input  rob_pkg::cmt_id_t             i_out_cmt_id,
  input  logic                         i_retire,
  input  logic                         i_flush,
  output logic                         o_exc_valid,
  output rob_pkg::cmt_id_t             o_exc_cmt_id,
  output rob_pkg::grp_id_t             o_exc_grp_id,
  output rob_pkg::except_t             o_exc_type
);

  logic             r_exc_valid;
  rob_pkg::cmt_id_t r_exc_cmt_id;
  rob_pkg::grp_id_t r_exc_grp_id;
  rob_pkg::except_t r_exc_type;

  logic             nxt_valid;
  rob_pkg::cmt_id_t nxt_cmt_id;
  rob_pkg::grp_id_t nxt_grp_id;
  rob_pkg::except_t nxt_type;

  rob_pkg::cmt_id_t                done_age [`ROB_CMT_BUS_SIZE];  // distance from head
  logic [`ROB_CMT_BUS_SIZE-1:0]    cand;

  // age is the distance from the head, equal ids fall back to the lane
  function automatic logic is_older(rob_pkg::cmt_id_t a_id, rob_pkg::grp_id_t a_grp,
                                    rob_pkg::cmt_id_t b_id, rob_pkg::grp_id_t b_grp,
                                    rob_pkg::cmt_id_t base);
    rob_pkg::cmt_id_t a_age;
    rob_pkg::cmt_id_t b_age;
    a_age = a_id - base;
    b_age = b_id - base;
    if (a_age != b_age) begin
      return a_age < b_age;
    end
    return a_grp < b_grp;  // one-hot lanes, lower bit is older
  endfunction

  // ------------------------------
  // candidates of this cycle
  // ------------------------------

  // reports outside the live window belong to retired entries
  for (genvar p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin : g_cand
    assign done_age[p] = i_done_cmt_id[p] - i_out_cmt_id;
    assign cand[p]     = i_done_valid[p] & i_done_except_valid[p] &
                         (done_age[p] < `ROB_ENTRY_SIZE);
  end

  always_comb begin
    nxt_valid  = r_exc_valid & ~(i_retire & (r_exc_cmt_id == i_out_cmt_id));
    nxt_cmt_id = r_exc_cmt_id;
    nxt_grp_id = r_exc_grp_id;
    nxt_type   = r_exc_type;
    for (int p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin
      if (cand[p] && (!nxt_valid ||
          is_older(i_done_cmt_id[p], i_done_grp_id[p], nxt_cmt_id, nxt_grp_id, i_out_cmt_id)))
      begin
        nxt_valid  = 1'b1;
        nxt_cmt_id = i_done_cmt_id[p];
        nxt_grp_id = i_done_grp_id[p];
        nxt_type   = i_done_except_type[p];
      end
    end
    if (i_flush) begin
      nxt_valid = 1'b0;  // all that is left in flight is dead
    end
  end

  // ------------------------------
  // held exception
  // ------------------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_exc_valid <= 1'b0;
    end else begin
      r_exc_valid <= nxt_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_exc_cmt_id <= nxt_cmt_id;
    r_exc_grp_id <= nxt_grp_id;
    r_exc_type   <= nxt_type;
  end

  assign o_exc_valid  = r_exc_valid;
  assign o_exc_cmt_id = r_exc_cmt_id;
  assign o_exc_grp_id = r_exc_grp_id;
  assign o_exc_type   = r_exc_type;

endmodule

// ==== hw/rob_pkg.sv ====
/*
  reorder buffer shared types
  ids with wrap bit, lane masks, pc and exception codes
*/
`include "rob_cfg.svh"

package rob_pkg;

  // ------------------------------
  // buffer ids
  // ------------------------------

  // entry index with one extra wrap bit on top, so a full buffer
  // and an empty buffer can be told apart
  typedef logic [`ROB_ENTRY_W:0] cmt_id_t;

  // plain entry index, without wrap bit
  typedef logic [`ROB_ENTRY_W-1:0] entry_idx_t;

  // ------------------------------
  // per group payload
  // ------------------------------

  // one bit per lane, lane 0 in bit 0
  typedef logic [`ROB_DISP_SIZE-1:0] grp_id_t;

  // instruction address
  typedef logic [`ROB_PC_W-1:0] pc_t;

  // exception cause, 0 means none on the commit port
  typedef logic [`ROB_EXC_W-1:0] except_t;

endpackage

// ==== hw/rob_top.sv ====
/*
  reorder buffer top
  allocation, entry storage, oldest exception and commit stage
*/
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_top (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  // dispatch
  input  logic                         i_disp_valid,
  input  rob_pkg::grp_id_t             i_disp_grp_id,
  input  rob_pkg::pc_t                 i_disp_pc,
  output rob_pkg::cmt_id_t             o_disp_cmt_id,
  // done reports
  input  logic [`ROB_CMT_BUS_SIZE-1:0] i_done_valid,
  input  rob_pkg::cmt_id_t             i_done_cmt_id       [`ROB_CMT_BUS_SIZE],
  input  rob_pkg::grp_id_t             i_done_grp_id       [`ROB_CMT_BUS_SIZE],
  input  logic [`ROB_CMT_BUS_SIZE-1:0] i_done_except_valid,
  input  rob_pkg::except_t             i_done_except_type  [`ROB_CMT_BUS_SIZE],
  // commit
  output logic                         o_cmt_valid,
  output rob_pkg::cmt_id_t             o_cmt_id,
  output rob_pkg::grp_id_t             o_cmt_grp_id,
  output rob_pkg::grp_id_t             o_cmt_dead_id,
  output rob_pkg::grp_id_t             o_cmt_except_valid,
  output rob_pkg::except_t             o_cmt_except_type,
  output rob_pkg::pc_t                 o_cmt_epc,
  output logic                         o_credit_return
);

  rob_pkg::cmt_id_t in_cmt_id, out_cmt_id;
  logic             head_done, retire, flush;
  rob_pkg::grp_id_t head_grp_id, head_dead;
  rob_pkg::pc_t     head_pc;
  logic             exc_valid;
  rob_pkg::cmt_id_t exc_cmt_id;
  rob_pkg::grp_id_t exc_grp_id;
  rob_pkg::except_t exc_type;

  assign o_disp_cmt_id = in_cmt_id;

  rob_alloc u_alloc (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_disp_valid(i_disp_valid), .i_retire(retire),
    .o_in_cmt_id(in_cmt_id), .o_out_cmt_id(out_cmt_id));

  rob_entry_array u_entry_array (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_disp_valid(i_disp_valid),
    .i_disp_grp_id(i_disp_grp_id), .i_disp_pc(i_disp_pc), .i_in_cmt_id(in_cmt_id),
    .i_out_cmt_id(out_cmt_id), .i_done_valid(i_done_valid), .i_done_cmt_id(i_done_cmt_id),
    .i_done_grp_id(i_done_grp_id), .i_retire(retire), .i_flush(flush),
    .o_head_done(head_done), .o_head_grp_id(head_grp_id), .o_head_dead(head_dead),
    .o_head_pc(head_pc));

  rob_except_sel u_except_sel (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_done_valid(i_done_valid),
    .i_done_cmt_id(i_done_cmt_id), .i_done_grp_id(i_done_grp_id),
    .i_done_except_valid(i_done_except_valid), .i_done_except_type(i_done_except_type),
    .i_out_cmt_id(out_cmt_id), .i_retire(retire), .i_flush(flush),
    .o_exc_valid(exc_valid), .o_exc_cmt_id(exc_cmt_id), .o_exc_grp_id(exc_grp_id),
    .o_exc_type(exc_type));

  rob_commit u_commit (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_out_cmt_id(out_cmt_id),
    .i_head_done(head_done), .i_head_grp_id(head_grp_id), .i_head_dead(head_dead),
    .i_head_pc(head_pc), .i_exc_valid(exc_valid), .i_exc_cmt_id(exc_cmt_id),
    .i_exc_grp_id(exc_grp_id), .i_exc_type(exc_type), .o_retire(retire), .o_flush(flush),
    .o_cmt_valid(o_cmt_valid), .o_cmt_id(o_cmt_id), .o_cmt_grp_id(o_cmt_grp_id),
    .o_cmt_dead_id(o_cmt_dead_id), .o_cmt_except_valid(o_cmt_except_valid),
    .o_cmt_except_type(o_cmt_except_type), .o_cmt_epc(o_cmt_epc),
    .o_credit_return(o_credit_return));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the reorder buffer testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_rob -o tb_rob_sim > build.log 2>&1 \
  && ./obj_dir/tb_rob_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log \
  && { echo "simulation FAILED, see sim.log"; exit 1; } \
  || { echo "simulation PASSED"; exit 0; }

// ==== verification/tb_rob_table.svh ====
/*
  reorder buffer stimulus table
  dispatch groups, done events and segment checks, in table order
*/
`ifndef TB_ROB_TABLE_SVH
`define TB_ROB_TABLE_SVH

// columns are kind, lanes, pc, slot, cmt id, lane, exception, type
// a run of done rows is one shuffle window and an idle row ends it
task automatic load_table();
  // ------------------------------
  // in order retire and a partial group
  // ------------------------------
  add_row(K_DISP, 2'b11, 32'h0000_1000, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b01, 32'h0000_1010, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_1020, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b1, 4'd0, 1'b1, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b0, 4'd1, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b1, 4'd2, 1'b1, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b0, 4'd2, 1'b0, 1'b0, 4'd0);
  add_row(K_WAIT, 2'b00, 32'h0,         1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  // lane 0 exception kills the younger group
  add_row(K_DISP, 2'b11, 32'h0000_2000, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_2010, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b0, 4'd3, 1'b0, 1'b1, 4'd5);
  add_row(K_DONE, 2'b00, 32'h0,         1'b1, 4'd3, 1'b1, 1'b0, 4'd0);
  add_row(K_WAIT, 2'b00, 32'h0,         1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  // older exception arrives in a later cycle
  add_row(K_DISP, 2'b11, 32'h0000_3000, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_3010, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_3020, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b0, 4'd6, 1'b0, 1'b1, 4'd3);
  add_row(K_IDLE, 2'b00, 32'h0,         1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b1, 4'd5, 1'b1, 1'b1, 4'd2);
  add_row(K_DONE, 2'b00, 32'h0,         1'b0, 4'd5, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b1, 4'd6, 1'b1, 1'b0, 4'd0);
  add_row(K_WAIT, 2'b00, 32'h0,         1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  // two exceptions in one cycle on the same group
  add_row(K_DISP, 2'b11, 32'h0000_4000, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_4010, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b0, 4'd8, 1'b1, 1'b1, 4'd4);
  add_row(K_DONE, 2'b00, 32'h0,         1'b1, 4'd8, 1'b0, 1'b1, 4'd6);
  add_row(K_WAIT, 2'b00, 32'h0,         1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  // ------------------------------
  // full buffer with id wrap and flush
  // ------------------------------
  add_row(K_DISP, 2'b01, 32'h0000_5000, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_5010, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_5020, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b01, 32'h0000_5030, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_5040, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_5050, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_5060, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DISP, 2'b11, 32'h0000_5070, 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
  add_row(K_DONE, 2'b00, 32'h0,         1'b1, 4'd10, 1'b0, 1'b1, 4'd9);
  add_row(K_WAIT, 2'b00, 32'h0,         1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
endtask

`endif

// ==== verification/tb_rob.sv ====
/*
  reorder buffer testbench
  table driven dispatch and done reports, shuffled per window,
  commits checked against a model of the retire and flush rules
*/
`timescale 1ns/10ps
`include "rob_cfg.svh"

module tb_rob;

  localparam int WAIT_LIMIT = 200;  // cycles per wait loop
  localparam int REC_W = `ROB_ENTRY_W + 1 + 3 * `ROB_DISP_SIZE + `ROB_EXC_W + `ROB_PC_W;
  localparam logic [1:0] K_DISP = 2'd0;
  localparam logic [1:0] K_DONE = 2'd1;
  localparam logic [1:0] K_IDLE = 2'd2;
  localparam logic [1:0] K_WAIT = 2'd3;

  typedef logic [REC_W-1:0] rec_t;  // id, lanes, dead, except, type, epc

  typedef struct packed {
    logic [1:0]       kind;
    rob_pkg::grp_id_t lanes;
    rob_pkg::pc_t     pc;
    logic             slot;
    rob_pkg::cmt_id_t cmt;
    logic             lane;
    logic             exc;
    rob_pkg::except_t typ;
  } row_t;

  logic                         i_clk = 1'b0;
  logic                         i_reset_n;
  logic                         i_disp_valid;
  rob_pkg::grp_id_t             i_disp_grp_id;
  rob_pkg::pc_t                 i_disp_pc;
  rob_pkg::cmt_id_t             o_disp_cmt_id;
  logic [`ROB_CMT_BUS_SIZE-1:0] i_done_valid;
  rob_pkg::cmt_id_t             i_done_cmt_id      [`ROB_CMT_BUS_SIZE];
  rob_pkg::grp_id_t             i_done_grp_id      [`ROB_CMT_BUS_SIZE];
  logic [`ROB_CMT_BUS_SIZE-1:0] i_done_except_valid;
  rob_pkg::except_t             i_done_except_type [`ROB_CMT_BUS_SIZE];
  logic                         o_cmt_valid;
  rob_pkg::cmt_id_t             o_cmt_id;
  rob_pkg::grp_id_t             o_cmt_grp_id;
  rob_pkg::grp_id_t             o_cmt_dead_id;
  rob_pkg::grp_id_t             o_cmt_except_valid;
  rob_pkg::except_t             o_cmt_except_type;
  rob_pkg::pc_t                 o_cmt_epc;
  logic                         o_credit_return;

  row_t             rows[$];
  rec_t             act_q[$];      // commits seen by the monitor
  rob_pkg::cmt_id_t seg_cmt[$];    // groups of the current segment
  rob_pkg::grp_id_t seg_lanes[$];
  rob_pkg::pc_t     seg_pc[$];
  rob_pkg::cmt_id_t seg_base;      // id of the oldest group in the segment
  logic             exc_seen;
  rob_pkg::cmt_id_t exc_age;
  logic             exc_lane;
  rob_pkg::except_t exc_type;
  logic [31:0]      lfsr_state;
  int               disp_count, commit_count, credit_count, checks, errors, timeouts;
  logic             timed_out;

  rob_top rob_top_i (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_disp_valid(i_disp_valid),
    .i_disp_grp_id(i_disp_grp_id), .i_disp_pc(i_disp_pc), .o_disp_cmt_id(o_disp_cmt_id),
    .i_done_valid(i_done_valid), .i_done_cmt_id(i_done_cmt_id), .i_done_grp_id(i_done_grp_id),
    .i_done_except_valid(i_done_except_valid), .i_done_except_type(i_done_except_type),
    .o_cmt_valid(o_cmt_valid), .o_cmt_id(o_cmt_id), .o_cmt_grp_id(o_cmt_grp_id),
    .o_cmt_dead_id(o_cmt_dead_id), .o_cmt_except_valid(o_cmt_except_valid),
    .o_cmt_except_type(o_cmt_except_type), .o_cmt_epc(o_cmt_epc),
    .o_credit_return(o_credit_return));

  always #5 i_clk = ~i_clk;

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic add_row(input logic [1:0] kind, input rob_pkg::grp_id_t lanes,
                         input rob_pkg::pc_t pc, input logic slot, input rob_pkg::cmt_id_t cmt,
                         input logic lane, input logic exc, input rob_pkg::except_t typ);
    rows.push_back('{kind, lanes, pc, slot, cmt, lane, exc, typ});
  endtask

  `include "tb_rob_table.svh"

  // galois lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic int pick_index(input int n);
    int v;
    v = 0;
    for (int b = 0; b < 3; b++) begin
      v = (v << 1) | lfsr_bit();
    end
    return v % n;
  endfunction

  function automatic rec_t pack_commit(input rob_pkg::cmt_id_t id, input rob_pkg::grp_id_t grp,
                                       input rob_pkg::grp_id_t dead, input rob_pkg::grp_id_t exc,
                                       input rob_pkg::except_t typ, input rob_pkg::pc_t epc);
    return {id, grp, dead, exc, typ, epc};
  endfunction

  task automatic clear_inputs();
    i_disp_valid        = 1'b0;
    i_disp_grp_id       = '0;
    i_disp_pc           = '0;
    i_done_valid        = '0;
    i_done_except_valid = '0;
    for (int p = 0; p < `ROB_CMT_BUS_SIZE; p++) begin
      i_done_cmt_id[p]      = '0;
      i_done_grp_id[p]      = '0;
      i_done_except_type[p] = '0;
    end
  endtask

  // dispatcher only runs ahead by the returned credits
  task automatic wait_credit();
    int cycles;
    cycles = 0;
    @(posedge i_clk);
    while (disp_count - credit_count >= `ROB_ENTRY_SIZE) begin
      if (cycles >= WAIT_LIMIT) begin
        $display("timeout: no dispatch credit came back after %0d cycles", cycles);
        timeouts++;
        timed_out = 1'b1;
        return;
      end
      cycles++;
      @(posedge i_clk);
    end
  endtask

  task automatic dispatch_group(input row_t r);
    rob_pkg::cmt_id_t exp_id;
    wait_credit();
    if (timed_out) begin
      return;
    end
    exp_id = disp_count % (2 * `ROB_ENTRY_SIZE);  // id wraps after twice the entries
    @(negedge i_clk);
    assert (o_disp_cmt_id == exp_id) else begin
      errors++;
      $display("ERROR %0t: dispatch id %0d, expected %0d", $time, o_disp_cmt_id, exp_id);
    end
    i_disp_valid  = 1'b1;
    i_disp_grp_id = r.lanes;
    i_disp_pc     = r.pc;
    seg_cmt.push_back(exp_id);
    seg_lanes.push_back(r.lanes);
    seg_pc.push_back(r.pc);
    disp_count++;
    @(negedge i_clk);
    clear_inputs();
  endtask

  // ------------------------------
  // done events of one window
  // ------------------------------
  task automatic apply_events(input int first, input int count);
    int                           order[$];
    int                           pick;
    int                           tmp;
    logic [`ROB_CMT_BUS_SIZE-1:0] used;
    row_t                         r;
    rob_pkg::cmt_id_t             age;
    for (int k = 0; k < count; k++) begin
      order.push_back(first + k);
    end
    for (int k = count - 1; k > 0; k--) begin
      pick       = pick_index(k + 1);
      tmp        = order[k];
      order[k]   = order[pick];
      order[pick] = tmp;
    end
    used = '0;
    @(negedge i_clk);
    for (int k = 0; k < count; k++) begin
      r = rows[order[k]];
      if (used[r.slot]) begin  // port taken so wait a cycle
        @(negedge i_clk);
        clear_inputs();
        used = '0;
      end
      i_done_valid[r.slot]        = 1'b1;
      i_done_cmt_id[r.slot]       = r.cmt;
      i_done_grp_id[r.slot]       = rob_pkg::grp_id_t'(1) << r.lane;
      i_done_except_valid[r.slot] = r.exc;
      i_done_except_type[r.slot]  = r.typ;
      used[r.slot]                = 1'b1;
      // model keeps the oldest report by group and then by lane
      age = r.cmt - seg_base;
      if (r.exc && (!exc_seen || age < exc_age || (age == exc_age && r.lane < exc_lane))) begin
        exc_seen = 1'b1;
        exc_age  = age;
        exc_lane = r.lane;
        exc_type = r.typ;
      end
    end
    @(negedge i_clk);
    clear_inputs();
  endtask

  // ------------------------------
  // reference model and compare
  // ------------------------------
  task automatic check_segment();
    rec_t             exp_q[$];
    rec_t             exp_rec;
    rec_t             act_rec;
    rob_pkg::grp_id_t lanes;
    rob_pkg::grp_id_t above;
    logic             killed;
    int               cycles;
    killed = 1'b0;
    for (int k = 0; k < seg_cmt.size(); k++) begin
      lanes = seg_lanes[k];
      if (killed) begin
        exp_rec = pack_commit(seg_cmt[k], lanes, lanes, '0, '0, seg_pc[k]);
      end else if (exc_seen && exc_age == k) begin
        for (int n = 0; n < `ROB_DISP_SIZE; n++) begin
          above[n] = (n > exc_lane);
        end
        exp_rec = pack_commit(seg_cmt[k], lanes, above & lanes,
                              rob_pkg::grp_id_t'(1) << exc_lane, exc_type,
                              seg_pc[k] + 4 * exc_lane);
        killed = 1'b1;  // everything younger dies
      end else begin
        exp_rec = pack_commit(seg_cmt[k], lanes, '0, '0, '0, seg_pc[k]);
      end
      exp_q.push_back(exp_rec);
    end
    cycles = 0;
    @(posedge i_clk);
    while (act_q.size() < exp_q.size()) begin
      if (cycles >= WAIT_LIMIT) begin
        $display("timeout: only %0d of %0d commits arrived", act_q.size(), exp_q.size());
        timeouts++;
        timed_out = 1'b1;
        return;
      end
      cycles++;
      @(posedge i_clk);
    end
    while (exp_q.size() > 0) begin
      exp_rec = exp_q.pop_front();
      act_rec = act_q.pop_front();
      checks++;
      assert (act_rec == exp_rec) else begin
        errors++;
        $display("ERROR %0t: commit record %h, expected %h", $time, act_rec, exp_rec);
      end
    end
    seg_cmt.delete();
    seg_lanes.delete();
    seg_pc.delete();
    exc_seen = 1'b0;
    seg_base = disp_count % (2 * `ROB_ENTRY_SIZE);
  endtask

  // commit monitor with one credit per commit
  always @(negedge i_clk) begin
    assert (o_credit_return == o_cmt_valid) else begin
      errors++;
      $display("ERROR %0t: credit %0b with commit valid %0b", $time, o_credit_return,
               o_cmt_valid);
    end
    if (o_credit_return) begin
      credit_count++;
    end
    if (o_cmt_valid) begin
      commit_count++;
      act_q.push_back(pack_commit(o_cmt_id, o_cmt_grp_id, o_cmt_dead_id, o_cmt_except_valid,
                                  o_cmt_except_type, o_cmt_epc));
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int row;
    int last;
    i_reset_n    = 1'b0;
    clear_inputs();
    lfsr_state   = 32'd85118;
    disp_count   = 0;
    commit_count = 0;
    credit_count = 0;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    timed_out    = 1'b0;
    exc_seen     = 1'b0;
    seg_base     = '0;
    load_table();
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    row = 0;
    while (row < rows.size() && !timed_out) begin
      case (rows[row].kind)
        K_DISP: begin
          dispatch_group(rows[row]);
          row++;
        end
        K_DONE: begin
          last = row;
          while (last < rows.size() && rows[last].kind == K_DONE) begin
            last++;
          end
          apply_events(row, last - row);
          row = last;
        end
        K_IDLE: begin
          @(negedge i_clk);
          row++;
        end
        default: begin
          check_segment();
          row++;
        end
      endcase
    end
    repeat (4) @(negedge i_clk);  // let any stray commit show up
    assert (commit_count == disp_count && act_q.size() == 0) else begin
      errors++;
      $display("ERROR %0t: %0d commits for %0d dispatches", $time, commit_count, disp_count);
    end
    $display("dispatches %0d commits %0d credits %0d checked %0d errors %0d timeouts %0d",
             disp_count, commit_count, credit_count, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
